// File: src.f
src/mem_pkg.sv
src/fetch_unit.sv
src/load_store_unit.sv
src/bus_arbiter.sv
src/sram_slave.sv
src/mem_subsystem.sv
bench/tb_clock.sv
bench/tb_mem_subsystem.sv

// File: Makefile
TOP = tb_mem_subsystem

.PHONY: compile run clean

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): src.f $(wildcard src/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: bench/tb_mem_subsystem.sv
module tb_mem_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int line_words = 4;
    localparam int depth_words = 256;
    // About 40 accesses of at most 10 cycles each, five times over
    localparam int max_cycles = 5 * 40 * 10;

    logic clock, reset;
    logic fetch_start;
    logic [31:0] fetch_addr;
    logic [31:0] instr;
    logic instr_valid, fetch_done, fetch_busy;
    logic mem_start, mem_write;
    logic [31:0] mem_addr, mem_wdata;
    logic [3:0] mem_wstrb;
    logic [31:0] mem_rdata;
    logic mem_err, mem_done, mem_busy;

    logic [31:0] ref_mem [depth_words];    // Expected memory contents
    logic [31:0] rand_state = 32'd41;
    int unsigned cycle_count = 0;

    // Events seen at the falling edges
    logic [31:0] instr_words [$];
    int unsigned instr_cycles [$];
    int unsigned words_at_done;
    logic fetch_done_seen, mem_done_seen;
    int unsigned fetch_done_cycle, mem_done_cycle;
    logic [31:0] done_rdata;
    logic done_err;

    tb_clock u_tb_clock (.clock(clock), .reset(reset));

    mem_subsystem u_mem_subsystem (.*);

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > max_cycles) begin
            $display("timeout: no end of the tests after %0d cycles", max_cycles);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic out_of_range(logic [31:0] addr);
        return (addr >> 2) >= depth_words;
    endfunction

    // Strobed bytes land, an access beyond the memory changes nothing
    function automatic void model_store(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
        if (!out_of_range(addr)) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) ref_mem[addr[9:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        assert (got === expected) else begin
            $display("mismatch %s: got %h, expected %h", name, got, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_bit(string name, logic got, logic expected);
        assert (got === expected) else begin
            $display("mismatch %s: got %h, expected %h", name, got, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Advance to the next falling edge and record what the DUT shows there
    task automatic step_cycle();
        @(negedge clock);
        if (instr_valid) begin
            instr_words.push_back(instr);
            instr_cycles.push_back(cycle_count);
        end
        if (fetch_done) begin
            check_true(instr_valid, "fetch_done came without an instruction word");
            fetch_done_seen = 1'b1;
            fetch_done_cycle = cycle_count;
            words_at_done = instr_words.size();
        end
        if (mem_done) begin
            mem_done_seen = 1'b1;
            mem_done_cycle = cycle_count;
            done_rdata = mem_rdata;
            done_err = mem_err;
        end
    endtask

    task automatic drive_access(logic write, logic [31:0] addr, logic [31:0] data,
                                logic [3:0] strb);
        check_true(!mem_busy, "load/store unit still busy at a new command");
        mem_start = 1'b1;
        mem_write = write;
        mem_addr = addr;
        mem_wdata = data;
        mem_wstrb = strb;
        mem_done_seen = 1'b0;
    endtask

    task automatic drive_fetch(logic [31:0] addr);
        check_true(!fetch_busy, "fetch unit still busy at a new line");
        fetch_start = 1'b1;
        fetch_addr = addr;
        fetch_done_seen = 1'b0;
        instr_words.delete();
        instr_cycles.delete();
    endtask

    task automatic end_pulse();
        step_cycle();
        mem_start = 1'b0;
        fetch_start = 1'b0;
    endtask

    task automatic wait_both_done();
        while (!(fetch_done_seen && mem_done_seen)) step_cycle();
    endtask

    task automatic check_load_result(logic [31:0] addr);
        logic [31:0] expected;
        expected = out_of_range(addr) ? 32'h0 : ref_mem[addr[9:2]];
        check_bit("mem_err", done_err, out_of_range(addr));
        check_value("mem_rdata", done_rdata, expected);
    endtask

    task automatic store_word(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
        drive_access(1'b1, addr, data, strb);
        end_pulse();
        while (!mem_done_seen) step_cycle();
        step_cycle();    // Unit is idle again one cycle after done
        check_bit("mem_err", done_err, out_of_range(addr));
        model_store(addr, data, strb);
    endtask

    task automatic load_word(logic [31:0] addr);
        drive_access(1'b0, addr, 32'h0, 4'h0);
        end_pulse();
        while (!mem_done_seen) step_cycle();
        step_cycle();
        check_load_result(addr);
    endtask

    task automatic check_line(logic [31:0] addr);
        repeat (3) step_cycle();    // A stray strobe after done would land here
        check_true(instr_words.size() == line_words, "wrong number of instruction words");
        check_true(words_at_done == line_words, "fetch_done not with the last word");
        for (int i = 0; i < line_words; i++) begin
            check_value("instr", instr_words[i], ref_mem[addr[9:2] + i]);
        end
    endtask

    task automatic check_outputs_idle();
        check_bit("instr_valid", instr_valid, 1'b0);
        check_bit("fetch_done", fetch_done, 1'b0);
        check_bit("mem_done", mem_done, 1'b0);
        check_bit("fetch_busy", fetch_busy, 1'b0);
        check_bit("mem_busy", mem_busy, 1'b0);
    endtask

    task automatic test_reset_state();
        do begin
            @(negedge clock);
            check_outputs_idle();
        end while (reset);
        repeat (2) begin
            step_cycle();
            check_outputs_idle();
        end
    endtask

    task automatic test_store_load();
        for (int i = 0; i < 8; i++) store_word(32'(i * 12 + 8), next_random(), 4'hf);
        for (int i = 0; i < 8; i++) load_word(32'(i * 12 + 8));
    endtask

    task automatic test_byte_strobes();
        store_word(32'h80, next_random(), 4'hf);
        for (int lane = 0; lane < 4; lane++) begin
            store_word(32'h80, next_random(), 4'(1 << lane));
            load_word(32'h80);
        end
    endtask

    task automatic test_line_fetch();
        for (int i = 0; i < line_words; i++) store_word(32'(32'h40 + 4 * i), next_random(), 4'hf);
        drive_fetch(32'h40);
        end_pulse();
        check_bit("fetch_busy", fetch_busy, 1'b1);
        while (!fetch_done_seen) step_cycle();
        check_line(32'h40);
    endtask

    task automatic test_priority();
        // Both in one cycle, fetch holds the lower request bit
        drive_fetch(32'h40);
        drive_access(1'b0, 32'd20, 32'h0, 4'h0);
        end_pulse();
        wait_both_done();
        check_true(fetch_done_cycle < mem_done_cycle, "load finished before the granted fetch");
        check_load_result(32'd20);
        check_line(32'h40);

        // Fetch raised while a load already owns the bus
        drive_access(1'b0, 32'd44, 32'h0, 4'h0);
        end_pulse();
        check_bit("mem_busy", mem_busy, 1'b1);
        drive_fetch(32'h40);
        end_pulse();
        wait_both_done();
        check_load_result(32'd44);
        check_line(32'h40);
        check_true(mem_done_cycle < instr_cycles[0], "instruction word before the load finished");
    endtask

    task automatic test_error_response();
        store_word(32'h4, next_random(), 4'hf);
        store_word(32'h404, next_random(), 4'hf);    // Word 257, low index bits hit word 1
        load_word(32'h404);
        load_word(32'h4);
        store_word(32'h1000_0000, next_random(), 4'h3);
        load_word(32'h1000_0000);
    endtask

    initial begin
        fetch_start = 1'b0;
        fetch_addr = 32'h0;
        mem_start = 1'b0;
        mem_write = 1'b0;
        mem_addr = 32'h0;
        mem_wdata = 32'h0;
        mem_wstrb = 4'h0;
        fetch_done_seen = 1'b0;
        mem_done_seen = 1'b0;

        test_reset_state();
        test_store_load();
        test_byte_strobes();
        test_line_fetch();
        test_priority();
        test_error_response();

        $display("TEST OK");
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
module tb_clock (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;    // 10 ns period
    end

    // Held over three rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset <= 1'b0;
    end

endmodule

// File: src/mem_subsystem.sv
module mem_subsystem #(
    parameter int data_width = 32,
    parameter int addr_width = 32,
    parameter int line_words = 4,
    parameter int depth_words = 256
) (
    input  logic clock,
    input  logic reset,
    input  logic fetch_start,
    input  logic [addr_width-1:0] fetch_addr,
    output logic [data_width-1:0] instr,
    output logic instr_valid, fetch_done, fetch_busy,
    input  logic mem_start, mem_write,
    input  logic [addr_width-1:0] mem_addr,
    input  logic [data_width-1:0] mem_wdata,
    input  logic [data_width/8-1:0] mem_wstrb,
    output logic [data_width-1:0] mem_rdata,
    output logic mem_err, mem_done, mem_busy
);
    // Fetch port, read channels only
    logic fetch_req;
    logic [addr_width-1:0] fetch_araddr;
    logic fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rlast, fetch_rready;
    logic [data_width-1:0] fetch_rdata;
    mem_pkg::axi_id_t fetch_arid, fetch_rid;
    mem_pkg::axi_len_t fetch_arlen;
    mem_pkg::axi_size_t fetch_arsize;
    mem_pkg::axi_burst_t fetch_arburst;
    mem_pkg::axi_resp_t fetch_rresp;

    // Load/store port
    logic lsu_req;
    logic [addr_width-1:0] lsu_araddr, lsu_awaddr;
    logic lsu_arvalid, lsu_rready, lsu_awvalid, lsu_wvalid, lsu_wlast, lsu_bready;
    logic lsu_arready, lsu_rvalid, lsu_rlast, lsu_awready, lsu_wready, lsu_bvalid;
    logic [data_width-1:0] lsu_wdata, lsu_rdata;
    logic [data_width/8-1:0] lsu_wstrb;
    mem_pkg::axi_id_t lsu_arid, lsu_awid, lsu_rid, lsu_bid;
    mem_pkg::axi_len_t lsu_arlen, lsu_awlen;
    mem_pkg::axi_size_t lsu_arsize, lsu_awsize;
    mem_pkg::axi_burst_t lsu_arburst, lsu_awburst;
    mem_pkg::axi_resp_t lsu_rresp, lsu_bresp;

    // Shared port into the SRAM
    logic [addr_width-1:0] araddr, awaddr;
    logic arvalid, rready, awvalid, wvalid, wlast, bready;
    logic arready, rvalid, rlast, awready, wready, bvalid;
    logic [data_width-1:0] wdata, rdata;
    logic [data_width/8-1:0] wstrb;
    mem_pkg::axi_id_t arid, awid, rid, bid;
    mem_pkg::axi_len_t arlen, awlen;
    mem_pkg::axi_size_t arsize, awsize;
    mem_pkg::axi_burst_t arburst, awburst;
    mem_pkg::axi_resp_t rresp, bresp;

    fetch_unit #(
        .data_width(data_width),
        .addr_width(addr_width),
        .line_words(line_words)
    ) u_fetch_unit (
        .clock(clock), .reset(reset),
        .start(fetch_start), .line_addr(fetch_addr), .req(fetch_req),
        .araddr(fetch_araddr), .arvalid(fetch_arvalid), .arready(fetch_arready),
        .arid(fetch_arid), .arlen(fetch_arlen), .arsize(fetch_arsize), .arburst(fetch_arburst),
        .rdata(fetch_rdata), .rresp(fetch_rresp), .rvalid(fetch_rvalid), .rlast(fetch_rlast),
        .rid(fetch_rid), .rready(fetch_rready),
        .instr(instr), .instr_valid(instr_valid), .done(fetch_done), .busy(fetch_busy)
    );

    load_store_unit #(
        .data_width(data_width),
        .addr_width(addr_width)
    ) u_load_store_unit (
        .clock(clock), .reset(reset),
        .start(mem_start), .write(mem_write), .addr(mem_addr),
        .store_data(mem_wdata), .store_strb(mem_wstrb), .req(lsu_req),
        .araddr(lsu_araddr), .awaddr(lsu_awaddr), .arvalid(lsu_arvalid), .rready(lsu_rready),
        .awvalid(lsu_awvalid), .wvalid(lsu_wvalid), .wlast(lsu_wlast), .bready(lsu_bready),
        .arid(lsu_arid), .awid(lsu_awid), .arlen(lsu_arlen), .awlen(lsu_awlen),
        .arsize(lsu_arsize), .awsize(lsu_awsize), .arburst(lsu_arburst), .awburst(lsu_awburst),
        .wdata(lsu_wdata), .wstrb(lsu_wstrb),
        .arready(lsu_arready), .rvalid(lsu_rvalid), .rlast(lsu_rlast),
        .awready(lsu_awready), .wready(lsu_wready), .bvalid(lsu_bvalid),
        .rdata(lsu_rdata), .rresp(lsu_rresp), .bresp(lsu_bresp), .rid(lsu_rid), .bid(lsu_bid),
        .rdata_out(mem_rdata), .err(mem_err), .done(mem_done), .busy(mem_busy)
    );

    // Lsu and shared ports match by name, fetch write side is tied off
    bus_arbiter #(
        .data_width(data_width),
        .addr_width(addr_width)
    ) u_bus_arbiter (
        .*,
        .ifu_req(fetch_req),
        .ifu_araddr(fetch_araddr), .ifu_arvalid(fetch_arvalid), .ifu_arready(fetch_arready),
        .ifu_arid(fetch_arid), .ifu_arlen(fetch_arlen), .ifu_arsize(fetch_arsize),
        .ifu_arburst(fetch_arburst), .ifu_rready(fetch_rready),
        .ifu_rvalid(fetch_rvalid), .ifu_rdata(fetch_rdata), .ifu_rresp(fetch_rresp),
        .ifu_rlast(fetch_rlast), .ifu_rid(fetch_rid),
        .ifu_awaddr('0), .ifu_awvalid(1'b0), .ifu_awid('0), .ifu_awlen('0),
        .ifu_awsize('0), .ifu_awburst('0), .ifu_awready(),
        .ifu_wdata('0), .ifu_wstrb('0), .ifu_wvalid(1'b0), .ifu_wlast(1'b0), .ifu_wready(),
        .ifu_bready(1'b0), .ifu_bvalid(), .ifu_bresp(), .ifu_bid()
    );

    sram_slave #(
        .data_width(data_width),
        .addr_width(addr_width),
        .depth_words(depth_words)
    ) u_sram_slave (
        .*
    );

endmodule

// File: src/sram_slave.sv
module sram_slave #(
    parameter int data_width = 32,
    parameter int addr_width = 32,
    parameter int depth_words = 256
) (
    input  logic clock,
    input  logic reset,
    input  logic [addr_width-1:0] araddr, awaddr,
    input  logic arvalid, rready, awvalid, wvalid, wlast, bready,
    input  mem_pkg::axi_id_t arid, awid,
    input  mem_pkg::axi_len_t arlen, awlen,
    input  mem_pkg::axi_size_t arsize, awsize,
    input  mem_pkg::axi_burst_t arburst, awburst,
    input  logic [data_width-1:0] wdata,
    input  logic [data_width/8-1:0] wstrb,
    output logic arready, rvalid, rlast, awready, wready, bvalid,
    output logic [data_width-1:0] rdata,
    output mem_pkg::axi_resp_t rresp, bresp,
    output mem_pkg::axi_id_t rid, bid
);
    localparam int offset_bits = $clog2(data_width / 8);
    localparam int index_bits = $clog2(depth_words);
    localparam mem_pkg::axi_size_t word_size = mem_pkg::axi_size_t'(offset_bits);

    typedef enum logic [1:0] {
        s_idle,
        s_read,
        s_write,
        s_resp
    } slave_state_t;

    slave_state_t state;
    logic [data_width-1:0] mem [depth_words];
    logic [addr_width-offset_bits-1:0] word;    // Byte offset dropped
    mem_pkg::axi_len_t beats_left;
    mem_pkg::axi_id_t id_q;
    mem_pkg::axi_resp_t bresp_q;
    logic attr_err;    // Size, burst type or length not supported
    logic range_err;
    logic beat_err;
    logic write_err;

    assign range_err = word >= depth_words;
    assign beat_err = attr_err || range_err;
    assign write_err = beat_err || !wlast;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: state <= arvalid ? s_read : (awvalid ? s_write : s_idle);
                s_read: state <= (rready && rlast) ? s_idle : s_read;
                s_write: state <= wvalid ? s_resp : s_write;
                s_resp: state <= bready ? s_idle : s_resp;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            word <= araddr[addr_width-1:offset_bits];
            beats_left <= arlen;
            id_q <= arid;
            attr_err <= arsize != word_size || arburst != mem_pkg::burst_incr;
        end else if (awvalid && awready) begin
            word <= awaddr[addr_width-1:offset_bits];
            id_q <= awid;
            attr_err <= awlen != '0 || awsize != word_size || awburst != mem_pkg::burst_incr;
        end else if (rvalid && rready) begin
            word <= word + 1'b1;    // Next beat of the burst
            beats_left <= beats_left - 1'b1;
        end
        if (wvalid && wready) begin
            bresp_q <= write_err ? mem_pkg::resp_slverr : mem_pkg::resp_okay;
            for (int b = 0; b < data_width / 8; b++) begin
                if (wstrb[b] && !write_err) begin
                    mem[word[index_bits-1:0]][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Read wins if both address channels show up together
    assign arready = state == s_idle;
    assign awready = state == s_idle && !arvalid;
    assign wready = state == s_write;

    assign rvalid = state == s_read;
    assign rlast = beats_left == '0;
    assign rdata = beat_err ? '0 : mem[word[index_bits-1:0]];
    assign rresp = beat_err ? mem_pkg::resp_slverr : mem_pkg::resp_okay;
    assign rid = id_q;

    assign bvalid = state == s_resp;    // One cycle after the w beat
    assign bresp = bresp_q;
    assign bid = id_q;

endmodule

// File: src/bus_arbiter.sv
module bus_arbiter #(
    parameter int data_width = 32,
    parameter int addr_width = 32
) (
    input  logic clock,
    input  logic reset,
    input  logic ifu_req,
    input  logic lsu_req,

    // Fetch unit side
    input  logic [addr_width-1:0] ifu_araddr, ifu_awaddr,
    input  logic ifu_arvalid, ifu_rready, ifu_awvalid, ifu_wvalid, ifu_wlast, ifu_bready,
    input  mem_pkg::axi_id_t ifu_arid, ifu_awid,
    input  mem_pkg::axi_len_t ifu_arlen, ifu_awlen,
    input  mem_pkg::axi_size_t ifu_arsize, ifu_awsize,
    input  mem_pkg::axi_burst_t ifu_arburst, ifu_awburst,
    input  logic [data_width-1:0] ifu_wdata,
    input  logic [data_width/8-1:0] ifu_wstrb,
    output logic ifu_arready, ifu_rvalid, ifu_rlast, ifu_awready, ifu_wready, ifu_bvalid,
    output logic [data_width-1:0] ifu_rdata,
    output mem_pkg::axi_resp_t ifu_rresp, ifu_bresp,
    output mem_pkg::axi_id_t ifu_rid, ifu_bid,

    // Load/store unit side
    input  logic [addr_width-1:0] lsu_araddr, lsu_awaddr,
    input  logic lsu_arvalid, lsu_rready, lsu_awvalid, lsu_wvalid, lsu_wlast, lsu_bready,
    input  mem_pkg::axi_id_t lsu_arid, lsu_awid,
    input  mem_pkg::axi_len_t lsu_arlen, lsu_awlen,
    input  mem_pkg::axi_size_t lsu_arsize, lsu_awsize,
    input  mem_pkg::axi_burst_t lsu_arburst, lsu_awburst,
    input  logic [data_width-1:0] lsu_wdata,
    input  logic [data_width/8-1:0] lsu_wstrb,
    output logic lsu_arready, lsu_rvalid, lsu_rlast, lsu_awready, lsu_wready, lsu_bvalid,
    output logic [data_width-1:0] lsu_rdata,
    output mem_pkg::axi_resp_t lsu_rresp, lsu_bresp,
    output mem_pkg::axi_id_t lsu_rid, lsu_bid,

    // Shared port toward the memory
    output logic [addr_width-1:0] araddr, awaddr,
    output logic arvalid, rready, awvalid, wvalid, wlast, bready,
    output mem_pkg::axi_id_t arid, awid,
    output mem_pkg::axi_len_t arlen, awlen,
    output mem_pkg::axi_size_t arsize, awsize,
    output mem_pkg::axi_burst_t arburst, awburst,
    output logic [data_width-1:0] wdata,
    output logic [data_width/8-1:0] wstrb,
    input  logic arready, rvalid, rlast, awready, wready, bvalid,
    input  logic [data_width-1:0] rdata,
    input  mem_pkg::axi_resp_t rresp, bresp,
    input  mem_pkg::axi_id_t rid, bid
);
    mem_pkg::arb_state_t state;
    logic [1:0] req;
    logic [1:0] grant;    // One-hot, bit 0 is fetch
    logic active;
    logic sel_ifu;

    assign req = {lsu_req, ifu_req};
    assign active = state == mem_pkg::work;
    assign sel_ifu = grant[0];

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= mem_pkg::idle;
            grant <= '0;
        end else if (state == mem_pkg::idle) begin
            if (|req) begin
                state <= mem_pkg::work;
                grant <= req & (~req + 2'd1);    // Lowest request wins
            end
        end else if ((rvalid && rready && rlast) || (bvalid && bready)) begin
            state <= mem_pkg::idle;
        end
    end

    // Address valids stay masked until the grant is registered
    assign arvalid = active && (sel_ifu ? ifu_arvalid : lsu_arvalid);
    assign awvalid = active && (sel_ifu ? ifu_awvalid : lsu_awvalid);

    assign {araddr, arid, arlen, arsize, arburst, rready} = sel_ifu
        ? {ifu_araddr, ifu_arid, ifu_arlen, ifu_arsize, ifu_arburst, ifu_rready}
        : {lsu_araddr, lsu_arid, lsu_arlen, lsu_arsize, lsu_arburst, lsu_rready};
    assign {awaddr, awid, awlen, awsize, awburst} = sel_ifu
        ? {ifu_awaddr, ifu_awid, ifu_awlen, ifu_awsize, ifu_awburst}
        : {lsu_awaddr, lsu_awid, lsu_awlen, lsu_awsize, lsu_awburst};
    assign {wvalid, wdata, wstrb, wlast, bready} = sel_ifu
        ? {ifu_wvalid, ifu_wdata, ifu_wstrb, ifu_wlast, ifu_bready}
        : {lsu_wvalid, lsu_wdata, lsu_wstrb, lsu_wlast, lsu_bready};

    // Loser sees no ready and no response
    assign {ifu_arready, ifu_awready} = (active && sel_ifu) ? {arready, awready} : '0;
    assign {lsu_arready, lsu_awready} = (active && grant[1]) ? {arready, awready} : '0;
    assign {ifu_rvalid, ifu_rdata, ifu_rresp, ifu_rlast, ifu_rid} = sel_ifu
        ? {rvalid, rdata, rresp, rlast, rid} : '0;
    assign {lsu_rvalid, lsu_rdata, lsu_rresp, lsu_rlast, lsu_rid} = grant[1]
        ? {rvalid, rdata, rresp, rlast, rid} : '0;
    assign {ifu_wready, ifu_bvalid, ifu_bresp, ifu_bid} = sel_ifu
        ? {wready, bvalid, bresp, bid} : '0;
    assign {lsu_wready, lsu_bvalid, lsu_bresp, lsu_bid} = grant[1]
        ? {wready, bvalid, bresp, bid} : '0;

endmodule

// File: src/load_store_unit.sv
module load_store_unit #(
    parameter int data_width = 32,
    parameter int addr_width = 32
) (
    input  logic clock,
    input  logic reset,
    // Core command
    input  logic start,
    input  logic write,
    input  logic [addr_width-1:0] addr,
    input  logic [data_width-1:0] store_data,
    input  logic [data_width/8-1:0] store_strb,
    output logic req,
    // AXI master port
    output logic [addr_width-1:0] araddr, awaddr,
    output logic arvalid, rready, awvalid, wvalid, wlast, bready,
    output mem_pkg::axi_id_t arid, awid,
    output mem_pkg::axi_len_t arlen, awlen,
    output mem_pkg::axi_size_t arsize, awsize,
    output mem_pkg::axi_burst_t arburst, awburst,
    output logic [data_width-1:0] wdata,
    output logic [data_width/8-1:0] wstrb,
    input  logic arready, rvalid, rlast, awready, wready, bvalid,
    input  logic [data_width-1:0] rdata,
    input  mem_pkg::axi_resp_t rresp, bresp,
    input  mem_pkg::axi_id_t rid, bid,
    // Core result
    output logic [data_width-1:0] rdata_out,
    output logic err,
    output logic done,
    output logic busy
);
    localparam mem_pkg::axi_size_t word_size = mem_pkg::axi_size_t'($clog2(data_width / 8));

    mem_pkg::master_state_t state;
    logic is_write;
    logic [addr_width-1:0] addr_q;
    logic [data_width-1:0] data_q;
    logic [data_width/8-1:0] strb_q;
    logic addr_beat, w_beat, r_beat, b_beat;

    assign addr_beat = is_write ? awvalid && awready : arvalid && arready;
    assign w_beat = wvalid && wready;
    assign r_beat = rvalid && rready && rlast && rid == mem_pkg::lsu_id;
    assign b_beat = bvalid && bready && bid == mem_pkg::lsu_id;

    // Store walks aw, w, b in turn, load walks ar, r
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= mem_pkg::m_idle;
        end else begin
            case (state)
                mem_pkg::m_idle: state <= start ? mem_pkg::m_addr : mem_pkg::m_idle;
                mem_pkg::m_addr: state <= addr_beat ? mem_pkg::m_data : mem_pkg::m_addr;
                mem_pkg::m_data: begin
                    if (w_beat) begin
                        state <= mem_pkg::m_resp;
                    end else if (r_beat) begin
                        state <= mem_pkg::m_idle;
                    end
                end
                mem_pkg::m_resp: state <= b_beat ? mem_pkg::m_idle : mem_pkg::m_resp;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == mem_pkg::m_idle && start) begin    // Command latched once per access
            is_write <= write;
            addr_q <= addr;
            data_q <= store_data;
            strb_q <= store_strb;
        end
    end

    assign req = state != mem_pkg::m_idle;
    assign busy = state != mem_pkg::m_idle;

    assign arvalid = state == mem_pkg::m_addr && !is_write;
    assign awvalid = state == mem_pkg::m_addr && is_write;
    assign {araddr, awaddr} = {addr_q, addr_q};
    assign {arid, awid} = {mem_pkg::lsu_id, mem_pkg::lsu_id};
    assign {arlen, awlen} = '0;    // Single beat
    assign {arsize, awsize} = {word_size, word_size};
    assign {arburst, awburst} = {mem_pkg::burst_incr, mem_pkg::burst_incr};

    assign wvalid = state == mem_pkg::m_data && is_write;
    assign wdata = data_q;
    assign wstrb = strb_q;
    assign wlast = 1'b1;
    assign rready = state == mem_pkg::m_data && !is_write;
    assign bready = state == mem_pkg::m_resp;

    assign rdata_out = rdata;
    assign done = r_beat || b_beat;
    assign err = r_beat ? (rresp != mem_pkg::resp_okay)
                        : (b_beat && bresp != mem_pkg::resp_okay);

endmodule

// File: src/fetch_unit.sv
module fetch_unit #(
    parameter int data_width = 32,
    parameter int addr_width = 32,
    parameter int line_words = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  logic [addr_width-1:0] line_addr,
    output logic req,
    // Read address channel
    output logic [addr_width-1:0] araddr,
    output logic arvalid,
    input  logic arready,
    output mem_pkg::axi_id_t arid,
    output mem_pkg::axi_len_t arlen,
    output mem_pkg::axi_size_t arsize,
    output mem_pkg::axi_burst_t arburst,
    // Read data channel
    input  logic [data_width-1:0] rdata,
    input  mem_pkg::axi_resp_t rresp,
    input  logic rvalid,
    input  logic rlast,
    input  mem_pkg::axi_id_t rid,
    output logic rready,
    // Core side
    output logic [data_width-1:0] instr,
    output logic instr_valid,
    output logic done,
    output logic busy
);
    localparam mem_pkg::axi_size_t word_size = mem_pkg::axi_size_t'($clog2(data_width / 8));

    mem_pkg::master_state_t state;
    logic r_beat;

    assign r_beat = rvalid && rready && rid == mem_pkg::fetch_id;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= mem_pkg::m_idle;
        end else begin
            case (state)
                mem_pkg::m_idle: state <= start ? mem_pkg::m_addr : mem_pkg::m_idle;
                mem_pkg::m_addr: state <= arready ? mem_pkg::m_data : mem_pkg::m_addr;
                mem_pkg::m_data: state <= (r_beat && rlast) ? mem_pkg::m_idle : mem_pkg::m_data;
                default: state <= mem_pkg::m_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == mem_pkg::m_idle && start) begin
            araddr <= line_addr;
        end
    end

    assign req = state != mem_pkg::m_idle;    // Raised together with arvalid
    assign busy = state != mem_pkg::m_idle;

    // One incrementing burst covers the whole line
    assign arvalid = state == mem_pkg::m_addr;
    assign arid = mem_pkg::fetch_id;
    assign arlen = mem_pkg::axi_len_t'(line_words - 1);
    assign arsize = word_size;
    assign arburst = mem_pkg::burst_incr;
    assign rready = state == mem_pkg::m_data;

    // A faulted beat hands the core an all-zero word, which decodes as illegal
    assign instr = (rresp == mem_pkg::resp_okay) ? rdata : '0;
    assign instr_valid = r_beat;
    assign done = r_beat && rlast;

endmodule

// File: src/mem_pkg.sv
package mem_pkg;

    // AXI field types shared by both masters, the arbiter and the SRAM
    typedef logic [3:0] axi_id_t;
    typedef logic [7:0] axi_len_t;    // Beats minus one
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t resp_okay = 2'd0;
    localparam axi_resp_t resp_slverr = 2'd2;

    localparam axi_burst_t burst_incr = 2'd1;

    // Fixed ids per master, echoed back by the slave
    localparam axi_id_t fetch_id = 4'd0;
    localparam axi_id_t lsu_id = 4'd1;

    typedef enum logic {
        idle,
        work
    } arb_state_t;

    typedef enum logic [1:0] {
        m_idle,
        m_addr,
        m_data,
        m_resp
    } master_state_t;

endpackage
